//--- verif/icache_stimulus.txt
// op (0 read, 1 invalidate, f end), address, expected data, expected hit, memory latency
// expected data is the inverted low 16 address bits over the low 16 address bits
// first fill after reset, then a hit.
0 00000013 ffec0013 0 2
0 00000013 ffec0013 1 0
0 00000025 ffda0025 0 0
0 00000025 ffda0025 1 0
// same index, other tag, replaces the line.
0 00000123 fedc0123 0 3
0 00000123 fedc0123 1 0
0 00000013 ffec0013 0 1
0 00000013 ffec0013 1 0
0 00000123 fedc0123 0 4
// fence, then refill.
1 00000000 00000000 0 0
0 00000123 fedc0123 0 5
0 00000025 ffda0025 0 6
0 00000025 ffda0025 1 0
// latency sweep on empty lines.
0 0000abc4 543babc4 0 7
0 00001238 edc71238 0 8
0 0000ffff 0000ffff 0 9
0 00004a5a b5a54a5a 0 a
0 0000700e 8ff1700e 0 b
0 00003c71 c38e3c71 0 c
0 0000abc4 543babc4 1 0
0 00001238 edc71238 1 0
// upper address bits are not part of the tag.
0 00050ab6 f5490ab6 0 2
0 00070ab6 f5490ab6 1 0
0 ffff0ab6 f5490ab6 1 0
1 00000000 00000000 0 0
0 ffff0ab6 f5490ab6 0 1
0 00000013 ffec0013 0 0
0 00003c71 c38e3c71 0 3
0 00003c71 c38e3c71 1 0
f 00000000 00000000 0 0

//--- vlog.f
+incdir+hw
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_miss_port.sv
hw/icache_top.sv
verif/icache_tb.sv

//--- Makefile
# Verilator build and run of the icache testbench.

SOURCES := $(filter-out +incdir+%,$(shell cat vlog.f)) hw/icache_cfg.svh

.PHONY: all build run clean

all: run

build: obj_dir/Vicache_tb

# rebuilt only when a source or the file list changes
obj_dir/Vicache_tb: vlog.f $(SOURCES)
	verilator --binary --timescale 1ns/1ns --top-module icache_tb -f vlog.f -o Vicache_tb

# pass is decided by the pass line in the log
run: obj_dir/Vicache_tb
	./obj_dir/Vicache_tb > sim.log 2>&1; cat sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

    localparam int MAX_TESTS = 64;

    logic                     clk;
    logic                     rst;
    icache_pkg::icache_word_t cpu_req_addr;
    logic                     cpu_req_valid;
    logic                     invalidate;
    icache_pkg::icache_word_t cpu_req_data;
    logic                     cpu_req_ready;
    icache_pkg::icache_word_t mem_req_data;
    logic                     mem_req_ready;
    icache_pkg::icache_word_t mem_req_addr;
    logic                     mem_req_valid;

    // five words per line: op, addr, data, hit, latency.
    icache_pkg::icache_word_t stim [0:5*MAX_TESTS-1];
    icache_pkg::icache_word_t req_log [$]; // every memory request address.
    icache_pkg::icache_word_t held_addr;
    icache_pkg::icache_word_t moved_addr;
    int mem_latency = 0;
    int mem_wait = 0;
    logic mem_busy = 1'b0;
    int addr_moves = 0;
    int valid_drops = 0;
    int errors = 0;
    int tests = 0;
    int passed = 0;
    int num_tests = 0;
    int max_latency = 0;
    int cycles = 0;
    int cycle_limit = 0;

    icache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .invalidate    (invalidate),
        .cpu_req_data  (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // inverted low half above the low half.
    function automatic icache_pkg::icache_word_t model_word(input icache_pkg::icache_word_t addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    // memory model, ready after mem_latency cycles of valid.
    initial
    begin
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        forever
        begin
            @(negedge clk);
            if (rst)
            begin
                mem_req_ready = 1'b0;
                mem_busy      = 1'b0;
            end
            else if (mem_req_valid)
            begin
                if (!mem_busy)
                begin
                    mem_busy  = 1'b1;
                    mem_wait  = 0;
                    held_addr = mem_req_addr;
                    req_log.push_back(mem_req_addr);
                end
                else if (mem_req_addr !== held_addr)
                begin
                    addr_moves = addr_moves + 1;
                    moved_addr = mem_req_addr;
                end
                if (mem_wait >= mem_latency)
                begin
                    mem_req_ready = 1'b1;
                    mem_req_data  = model_word(mem_req_addr);
                end
                else
                begin
                    mem_wait = mem_wait + 1;
                end
            end
            else
            begin
                if (mem_busy && mem_req_ready !== 1'b1)
                begin
                    valid_drops = valid_drops + 1; // request withdrawn early.
                end
                mem_busy      = 1'b0;
                mem_req_ready = 1'b0;
            end
        end
    end

    task automatic check_word(input string name, input icache_pkg::icache_word_t got,
                              input icache_pkg::icache_word_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input string desc, input int err_before);
        tests = tests + 1;
        if (errors == err_before)
        begin
            passed = passed + 1;
        end
        $display("test %0d %s: %s", tests, desc, (errors == err_before) ? "ok" : "bad");
    endtask

    task automatic run_test(input int t);
        icache_pkg::icache_word_t op;
        icache_pkg::icache_word_t addr;
        icache_pkg::icache_word_t exp_data;
        logic exp_hit;
        int edges;
        int req_before;
        int moves_before;
        int drops_before;
        int err_before;
        op           = stim[5*t];
        addr         = stim[5*t+1];
        exp_data     = stim[5*t+2];
        exp_hit      = stim[5*t+3][0];
        mem_latency  = int'(stim[5*t+4]);
        err_before   = errors;
        req_before   = req_log.size();
        moves_before = addr_moves;
        drops_before = valid_drops;
        @(negedge clk); // idle gap after the last response.
        check_flag("cpu_req_ready", cpu_req_ready, 1'b0); // one-cycle pulse.
        if (op == 32'h1)
        begin
            invalidate = 1'b1;
            @(negedge clk);
            invalidate = 1'b0;
            @(negedge clk);
            if (cpu_req_ready !== 1'b0 || req_log.size() != req_before)
            begin
                $display("invalidate gave a response or a memory request");
                errors = errors + 1;
            end
            report_test($sformatf("invalidate"), err_before);
        end
        else
        begin
            cpu_req_addr  = addr;
            cpu_req_valid = 1'b1;
            @(negedge clk);
            cpu_req_valid = 1'b0;
            cpu_req_addr  = ~addr; // don't care once accepted.
            edges = 1;
            while (cpu_req_ready !== 1'b1)
            begin
                @(negedge clk);
                edges = edges + 1;
            end
            check_word("cpu_req_data", cpu_req_data, exp_data);
            check_flag("hit", req_log.size() == req_before, exp_hit);
            if (exp_hit && edges != 2)
            begin
                $display("hit answered %0d edges after valid instead of 2", edges);
                errors = errors + 1;
            end
            if (!exp_hit && req_log.size() - req_before != 1)
            begin
                $display("miss made %0d memory requests instead of one",
                         req_log.size() - req_before);
                errors = errors + 1;
            end
            else if (!exp_hit)
            begin
                check_word("mem_req_addr", req_log[req_before], addr);
            end
            if (addr_moves != moves_before)
            begin
                check_word("mem_req_addr", moved_addr, req_log[req_before]);
            end
            if (valid_drops != drops_before)
            begin
                $display("mem_req_valid fell before memory raised mem_req_ready");
                errors = errors + 1;
            end
            report_test($sformatf("read %h", addr), err_before);
        end
    endtask

    initial
    begin
        int err_before;
        rst           = 1'b1;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        invalidate    = 1'b0;
        $readmemh("verif/icache_stimulus.txt", stim);
        while (num_tests < MAX_TESTS && stim[5*num_tests] != 32'hf)
        begin
            if (int'(stim[5*num_tests+4]) > max_latency)
            begin
                max_latency = int'(stim[5*num_tests+4]);
            end
            num_tests = num_tests + 1;
        end
        cycle_limit = num_tests * (max_latency + 10) + 50;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        err_before = errors;
        check_flag("cpu_req_ready", cpu_req_ready, 1'b0);
        check_flag("mem_req_valid", mem_req_valid, 1'b0);
        if (num_tests == 0)
        begin
            $display("no stimulus lines were read");
            errors = errors + 1;
        end
        report_test("reset", err_before);
        for (int t = 0; t < num_tests; t++)
        begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  icache_pkg::icache_word_t cpu_req_addr,
    input  logic                     cpu_req_valid,
    input  logic                     invalidate,
    output icache_pkg::icache_word_t cpu_req_data,
    output logic                     cpu_req_ready,
    input  icache_pkg::icache_word_t mem_req_data,
    input  logic                     mem_req_ready,
    output icache_pkg::icache_word_t mem_req_addr,
    output logic                     mem_req_valid
);

    logic                          accept;
    logic                          start_fill;
    logic                          fill_wr;
    logic                          rd_en;
    logic                          invalidate_all;
    logic                          hit;
    logic                          fill_done;
    icache_pkg::icache_word_t      fill_data;
    logic [`ICACHE_TAG_BITS-1:0]   req_tag;
    logic [`ICACHE_INDEX_BITS-1:0] req_index;

    icache_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .invalidate     (invalidate),
        .hit            (hit),
        .fill_done      (fill_done),
        .accept         (accept),
        .start_fill     (start_fill),
        .fill_wr        (fill_wr),
        .rd_en          (rd_en),
        .invalidate_all (invalidate_all),
        .cpu_req_ready  (cpu_req_ready)
    );

    icache_tag_store i_tag_store (
        .clk            (clk),
        .rst            (rst),
        .invalidate_all (invalidate_all),
        .fill_wr        (fill_wr),
        .req_index      (req_index),
        .req_tag        (req_tag),
        .hit            (hit)
    );

    icache_data_store i_data_store (
        .clk          (clk),
        .rst          (rst),
        .fill_wr      (fill_wr),
        .rd_en        (rd_en),
        .req_index    (req_index),
        .fill_data    (fill_data),
        .cpu_req_data (cpu_req_data)
    );

    // memory side.
    icache_miss_port i_miss_port (
        .clk           (clk),
        .rst           (rst),
        .accept        (accept),
        .start_fill    (start_fill),
        .cpu_req_addr  (cpu_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .req_tag       (req_tag),
        .req_index     (req_index),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .fill_done     (fill_done),
        .fill_data     (fill_data)
    );

endmodule

//--- hw/icache_miss_port.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_miss_port (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic                          start_fill,
    input  icache_pkg::icache_word_t      cpu_req_addr,
    input  icache_pkg::icache_word_t      mem_req_data,
    input  logic                          mem_req_ready,
    output logic [`ICACHE_TAG_BITS-1:0]   req_tag,
    output logic [`ICACHE_INDEX_BITS-1:0] req_index,
    output icache_pkg::icache_word_t      mem_req_addr,
    output logic                          mem_req_valid,
    output logic                          fill_done,
    output icache_pkg::icache_word_t      fill_data
);

    icache_pkg::icache_addr_u req_addr_q;
    logic                     pending_q;
    logic                     mem_take;

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr_q.word <= cpu_req_addr;
        end
    end

    assign req_tag      = req_addr_q.fields.tag;
    assign req_index    = req_addr_q.fields.index;
    assign mem_req_addr = req_addr_q.word; // full address, upper bits too.

    assign mem_take = pending_q && mem_req_ready;

    // outstanding read, held until memory takes it.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending_q <= 1'b0;
            fill_done <= 1'b0;
        end
        else
        begin
            if (start_fill)
            begin
                pending_q <= 1'b1;
            end
            else if (mem_take)
            begin
                pending_q <= 1'b0;
            end
            fill_done <= mem_take;
        end
    end

    assign mem_req_valid = pending_q;

    always_ff @(posedge clk)
    begin
        if (mem_take)
        begin
            fill_data <= mem_req_data; // sampled with ready.
        end
    end

endmodule

//--- hw/icache_data_store.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_data_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fill_wr,
    input  logic                          rd_en,
    input  logic [`ICACHE_INDEX_BITS-1:0] req_index,
    input  icache_pkg::icache_word_t      fill_data,
    output icache_pkg::icache_word_t      cpu_req_data
);

    icache_pkg::icache_word_t words [0:`ICACHE_LINES-1];

    always_ff @(posedge clk)
    begin
        if (fill_wr)
        begin
            words[req_index] <= fill_data;
        end
    end

    // holds the last hit between responses.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_req_data <= '0;
        end
        else if (rd_en)
        begin
            cpu_req_data <= words[req_index];
        end
    end

endmodule

//--- hw/icache_tag_store.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_tag_store (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          invalidate_all,
    input  logic                          fill_wr,
    input  logic [`ICACHE_INDEX_BITS-1:0] req_index,
    input  logic [`ICACHE_TAG_BITS-1:0]   req_tag,
    output logic                          hit
);

    logic [`ICACHE_LINES-1:0]    valid_q;
    logic [`ICACHE_TAG_BITS-1:0] tags [0:`ICACHE_LINES-1];

    // valid bits.
    always_ff @(posedge clk)
    begin
        if (rst || invalidate_all)
        begin
            valid_q <= '0;
        end
        else if (fill_wr)
        begin
            valid_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_wr)
        begin
            tags[req_index] <= req_tag;
        end
    end

    // compare against the latched request.
    assign hit = valid_q[req_index] && (tags[req_index] == req_tag);

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req_valid,
    input  logic invalidate,
    input  logic hit,
    input  logic fill_done,
    output logic accept,
    output logic start_fill,
    output logic fill_wr,
    output logic rd_en,
    output logic invalidate_all,
    output logic cpu_req_ready
);

    icache_pkg::icache_state_e state_q;
    icache_pkg::icache_state_e state_d;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= icache_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_comb
    begin
        state_d        = state_q;
        accept         = 1'b0;
        start_fill     = 1'b0;
        fill_wr        = 1'b0;
        rd_en          = 1'b0;
        invalidate_all = 1'b0;
        case (state_q)
            icache_pkg::IDLE:
            begin
                if (invalidate)
                begin
                    invalidate_all = 1'b1; // fence, no response.
                end
                else if (cpu_req_valid)
                begin
                    accept  = 1'b1;
                    state_d = icache_pkg::COMPARE;
                end
            end
            icache_pkg::COMPARE:
            begin
                if (hit)
                begin
                    rd_en   = 1'b1;
                    state_d = icache_pkg::IDLE;
                end
                else
                begin
                    start_fill = 1'b1;
                    state_d    = icache_pkg::ALLOCATE;
                end
            end
            icache_pkg::ALLOCATE:
            begin
                // wait out the memory latency.
                if (fill_done)
                begin
                    fill_wr = 1'b1;
                    state_d = icache_pkg::COMPARE; // retry, now hits.
                end
            end
            default:
            begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    // strobe lines up with the registered read data.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cpu_req_ready <= 1'b0;
        end
        else
        begin
            cpu_req_ready <= rd_en;
        end
    end

endmodule

//--- hw/icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_WORD_BITS-1:0] icache_word_t;

    // bits above the tag are not compared.
    typedef struct packed {
        logic [`ICACHE_WORD_BITS-`ICACHE_TAG_BITS-`ICACHE_INDEX_BITS-1:0] upper;
        logic [`ICACHE_TAG_BITS-1:0]                                       tag;
        logic [`ICACHE_INDEX_BITS-1:0]                                     index;
    } icache_addr_fields_s;

    // raw word for memory, fields for the stores.
    typedef union packed {
        icache_word_t        word;
        icache_addr_fields_s fields;
    } icache_addr_u;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        COMPARE  = 2'd1,
        ALLOCATE = 2'd2
    } icache_state_e;

endpackage

//--- hw/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// line index, address bits 3..0.
`define ICACHE_INDEX_BITS 4

// tag, address bits 15..4.
`define ICACHE_TAG_BITS 12

// one word per line.
`define ICACHE_LINES 16

// data and address words.
`define ICACHE_WORD_BITS 32

`endif
